/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := vm16_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* project.f */
+incdir+verification
verilog/vm16_pkg.sv
verilog/vm16_bram.sv
verilog/vm16_decoder.sv
verilog/vm16_alu.sv
verilog/vm16_regfile.sv
verilog/vm16_mmu.sv
verilog/vm16_control.sv
verilog/vm16_gpio_apb.sv
verilog/vm16_soc.sv
verification/vm16_tb.sv

/* verification/vm16_programs.svh */
// instruction encoders and the table of test programs with expected gpio values
`ifndef VM16_PROGRAMS_SVH
`define VM16_PROGRAMS_SVH

localparam int         ROWS      = 18;
localparam int         MAX_LEN   = 12;
localparam logic [7:0] GPIO_ADDR = 8'hC0;

logic [15:0] prog_mem [ROWS][MAX_LEN];
int          prog_len [ROWS];
logic [7:0]  prog_exp [ROWS];
int          row_fill;

// register form: opcode rd ra low five bits
function automatic logic [15:0] reg_instr(input opcode_e op, input logic [2:0] rd,
                                          input logic [2:0] ra, input logic [4:0] low);
    return {op, rd, ra, low};
endfunction

// immediate form, raw opcode so undefined ones can be built too
function automatic logic [15:0] imm_instr(input logic [4:0] op, input logic [2:0] rd,
                                          input logic [7:0] imm);
    return {op, rd, imm};
endfunction

function automatic logic [15:0] load_imm(input logic [2:0] rd, input logic [7:0] imm);
    return imm_instr(OP_MOVI, rd, imm);
endfunction

// rd holds the data, ra the base, off is signed
function automatic logic [15:0] store_word(input logic [2:0] rd, input logic [2:0] ra,
                                           input logic [4:0] off);
    return reg_instr(OP_SW, rd, ra, off);
endfunction

function automatic logic [15:0] load_word(input logic [2:0] rd, input logic [2:0] ra,
                                          input logic [4:0] off);
    return reg_instr(OP_LW, rd, ra, off);
endfunction

task automatic append_instr(input logic [15:0] word);
    prog_mem[row_fill][prog_len[row_fill]] = word;
    prog_len[row_fill] += 1;
endtask

task automatic close_row(input logic [7:0] expected);
    prog_exp[row_fill] = expected;
    row_fill += 1;
endtask

// r1 = a, r2 = b, then op_word on r1 and r2, r1 goes to gpio
task automatic alu_row(input logic [15:0] op_word, input logic [7:0] a,
                       input logic [7:0] b, input logic [7:0] expected);
    append_instr(load_imm(3'd1, a));
    append_instr(load_imm(3'd2, b));
    append_instr(op_word);
    append_instr(load_imm(3'd0, GPIO_ADDR));
    append_instr(store_word(3'd1, 3'd0, 5'd0));
    close_row(expected);
endtask

// v written to gpio, read back into r3, k added, result written again
task automatic readback_row(input logic [7:0] v, input logic [7:0] k,
                            input logic [7:0] expected);
    append_instr(load_imm(3'd0, GPIO_ADDR));
    append_instr(load_imm(3'd1, v));
    append_instr(store_word(3'd1, 3'd0, 5'd0));
    append_instr(load_word(3'd3, 3'd0, 5'd0));
    append_instr(load_imm(3'd2, k));
    append_instr(reg_instr(OP_ARITH_U, 3'd3, 3'd2, FN_UADD));
    append_instr(store_word(3'd3, 3'd0, 5'd0));
    close_row(expected);
endtask

task automatic build_table();
    row_fill = 0;
    for (int r = 0; r < ROWS; r++) begin
        prog_len[r] = 0;
        prog_exp[r] = '0;
    end
    // r5 still holds its reset index
    append_instr(load_imm(3'd0, GPIO_ADDR));
    append_instr(store_word(3'd5, 3'd0, 5'd0));
    close_row(8'h05);
    // one row per kept function
    alu_row(reg_instr(OP_BIT, 3'd1, 3'd2, FN_OR), 8'h5A, 8'h0F, 8'h5F);
    alu_row(reg_instr(OP_BIT, 3'd1, 3'd2, FN_XOR), 8'h5A, 8'hFF, 8'hA5);
    alu_row(reg_instr(OP_BIT, 3'd1, 3'd2, FN_AND), 8'hF3, 8'h3C, 8'h30);
    alu_row(reg_instr(OP_BIT, 3'd1, 3'd2, FN_NOT), 8'h11, 8'h96, 8'h69);
    alu_row(reg_instr(OP_BIT, 3'd1, 3'd2, FN_LSHFT), 8'h0B, 8'h03, 8'h58);
    alu_row(reg_instr(OP_BIT, 3'd1, 3'd2, FN_RSHFT), 8'hB4, 8'h02, 8'h2D);
    alu_row(reg_instr(OP_ARITH_U, 3'd1, 3'd2, FN_UADD), 8'hF0, 8'h25, 8'h15);
    alu_row(reg_instr(OP_ARITH_U, 3'd1, 3'd2, FN_USUB), 8'h03, 8'h05, 8'hFE);
    // undefined opcode and function codes leave r1 alone
    alu_row(imm_instr(5'h1E, 3'd1, 8'hFF), 8'h3A, 8'h11, 8'h3A);
    alu_row(reg_instr(OP_BIT, 3'd1, 3'd2, 5'h0A), 8'h3A, 8'h11, 8'h3A);
    alu_row(reg_instr(OP_ARITH_U, 3'd1, 3'd2, 5'h01), 8'h3A, 8'h11, 8'h3A);
    // register move
    append_instr(load_imm(3'd3, 8'h62));
    append_instr(reg_instr(OP_MOV, 3'd5, 3'd3, 5'd0));
    append_instr(load_imm(3'd0, GPIO_ADDR));
    append_instr(store_word(3'd5, 3'd0, 5'd0));
    close_row(8'h62);
    // scratch round trip at r7+3
    append_instr(load_imm(3'd4, 8'h77));
    append_instr(load_imm(3'd7, 8'h10));
    append_instr(store_word(3'd4, 3'd7, 5'd3));
    append_instr(load_imm(3'd4, 8'h00));
    append_instr(load_word(3'd6, 3'd7, 5'd3));
    append_instr(load_imm(3'd0, GPIO_ADDR));
    append_instr(store_word(3'd6, 3'd0, 5'd0));
    close_row(8'h77);
    readback_row(8'h9C, 8'h7B, 8'h17);
    readback_row(8'h21, 8'h05, 8'h26);
    // offsets +2 and -3 both land on 0xC0
    append_instr(load_imm(3'd0, 8'hBE));
    append_instr(load_imm(3'd1, 8'h4D));
    append_instr(store_word(3'd1, 3'd0, 5'd2));
    close_row(8'h4D);
    append_instr(load_imm(3'd0, 8'hC3));
    append_instr(load_imm(3'd1, 8'hD2));
    append_instr(store_word(3'd1, 3'd0, 5'h1D));
    close_row(8'hD2);
endtask

`endif

/* verification/vm16_tb.sv */
// testbench for the vm16 SoC
// loads each table program, runs it and checks the gpio output
`timescale 1ns/1ps

module vm16_tb import vm16_pkg::*; ();

    localparam int INSTR_DEPTH   = 64;
    localparam int SCRATCH_DEPTH = 64;
    localparam int GPIO_WIDTH    = 8;
    localparam int IADDR_WIDTH   = $clog2(INSTR_DEPTH);
    localparam int CLK_PERIOD    = 4;

    logic                   clk;
    logic                   reset;
    logic                   load_we;
    logic [IADDR_WIDTH-1:0] load_addr;
    logic [DATA_WIDTH-1:0]  load_data;
    logic [GPIO_WIDTH-1:0]  gpio;
    logic [DATA_WIDTH-1:0]  pc;
    int                     errors;
    int                     checks;

    `include "vm16_programs.svh"

    // twice the worst-case time of every row
    localparam int WATCHDOG_NS = ROWS * (MAX_LEN * 8 + 20) * CLK_PERIOD * 2;

    vm16_soc #(
        .INSTR_DEPTH   (INSTR_DEPTH),
        .SCRATCH_DEPTH (SCRATCH_DEPTH),
        .GPIO_WIDTH    (GPIO_WIDTH)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .gpio      (gpio),
        .pc        (pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        checks += 1;
        if (got !== expected) begin
            errors += 1;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    // program goes in under reset, rest of the memory filled with NOP
    task automatic run_row(input int r);
        @(negedge clk);
        reset = 1'b1;
        for (int a = 0; a < INSTR_DEPTH; a++) begin
            load_we   = 1'b1;
            load_addr = IADDR_WIDTH'(a);
            if (a < prog_len[r]) begin
                load_data = prog_mem[r][a];
            end else begin
                load_data = reg_instr(OP_NOP, 3'd0, 3'd0, 5'd0);
            end
            @(negedge clk);
        end
        load_we = 1'b0;
        repeat (4) @(negedge clk);
        // program counter is cleared while reset is held
        check_value($sformatf("pc (row %0d)", r), pc, 16'h0000);
        reset = 1'b0;
        // at most 8 cycles per instruction
        repeat (prog_len[r] * 8 + 20) @(negedge clk);
        check_value($sformatf("gpio (row %0d)", r), {8'h00, gpio}, {8'h00, prog_exp[r]});
    endtask

    initial begin
        reset     = 1'b1;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        errors    = 0;
        checks    = 0;
        build_table();
        if (row_fill != ROWS) begin
            errors += 1;
            $display("program table holds %0d rows instead of %0d", row_fill, ROWS);
        end
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the programs did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

/* verilog/vm16_alu.sv */
// combinational ALU
`timescale 1ns/1ps

module vm16_alu import vm16_pkg::*; (
    input  alu_op_e               op,
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    output logic [DATA_WIDTH-1:0] c
);

    always_comb begin
        case (op)
            // moves and memory ops forward the second operand
            ALU_LW,
            ALU_SW,
            ALU_MOV,
            ALU_MOVI:  c = b;
            ALU_OR:    c = a | b;
            ALU_XOR:   c = a ^ b;
            ALU_AND:   c = a & b;
            ALU_NOT:   c = ~b;
            ALU_LSHFT: c = a << b;
            ALU_RSHFT: c = a >> b;
            // unsigned, wraps at the word width
            ALU_UADD:  c = a + b;
            ALU_USUB:  c = a - b;
            default:   c = '0;
        endcase
    end

endmodule

/* verilog/vm16_bram.sv */
// synchronous RAM, one write port and one registered read port
`timescale 1ns/1ps

module vm16_bram #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);
    logic [WIDTH-1:0] mem [DEPTH];

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

/* verilog/vm16_control.sv */
// instruction sequencer: program counter, FSM, operand latches, writeback
`timescale 1ns/1ps

module vm16_control import vm16_pkg::*; #(
    parameter int INSTR_DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     reset,
    output logic [DATA_WIDTH-1:0]    pc,
    input  logic [DATA_WIDTH-1:0]    instr_word,
    input  logic [REG_SEL_WIDTH-1:0] rd,
    input  logic [REG_SEL_WIDTH-1:0] ra,
    input  logic [7:0]               imm8,
    input  logic [4:0]               simm5,
    input  logic                     has_imm8,
    input  logic                     has_we,
    input  logic                     has_mem,
    input  logic                     has_mem_we,
    output logic [REG_SEL_WIDTH-1:0] reg_rs,
    input  logic [DATA_WIDTH-1:0]    reg_rdata,
    output logic                     reg_we,
    output logic [DATA_WIDTH-1:0]    reg_wdata,
    output logic [DATA_WIDTH-1:0]    alu_a,
    output logic [DATA_WIDTH-1:0]    alu_b,
    input  logic [DATA_WIDTH-1:0]    alu_c,
    output logic                     req,
    input  logic                     busy,
    output logic [DATA_WIDTH-1:0]    mmu_addr,
    output logic [DATA_WIDTH-1:0]    mmu_wdata,
    output logic                     mmu_we,
    input  logic [DATA_WIDTH-1:0]    mmu_rdata,
    output instr_t                   instr
);
    localparam logic [2:0] S_FETCH   = 3'd0;
    localparam logic [2:0] S_READ_RD = 3'd1;
    localparam logic [2:0] S_READ_RA = 3'd2;
    localparam logic [2:0] S_MEM     = 3'd3;
    localparam logic [2:0] S_WB      = 3'd4;

    logic [2:0]            state;
    logic [DATA_WIDTH-1:0] rd_val;
    logic [DATA_WIDTH-1:0] ra_val;

    // one read port, rd then ra over two cycles
    assign reg_rs    = (state == S_READ_RA) ? ra : rd;
    assign alu_a     = rd_val;
    assign alu_b     = ra_val;
    // base from the ALU plus sign-extended offset
    assign mmu_addr  = alu_c + {{(DATA_WIDTH-5){simm5[4]}}, simm5};
    assign mmu_wdata = rd_val;
    assign mmu_we    = has_mem_we && (state == S_MEM);
    assign reg_we    = has_we && (state == S_WB);
    assign reg_wdata = has_mem ? mmu_rdata : alu_c;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
            pc    <= '0;
            instr <= '0;
            req   <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    instr <= instr_word;
                    // stick at the last instruction word
                    if (pc < DATA_WIDTH'(INSTR_DEPTH - 1)) begin
                        pc <= pc + 1'b1;
                    end
                    state <= S_READ_RD;
                end
                S_READ_RD: begin
                    state <= S_READ_RA;
                end
                S_READ_RA: begin
                    if (has_mem) begin
                        state <= S_MEM;
                        req   <= 1'b1;
                    end else begin
                        state <= S_WB;
                    end
                end
                S_MEM: begin
                    req <= 1'b0;
                    // busy covers the req cycle itself
                    if (!busy) begin
                        state <= S_WB;
                    end
                end
                default: begin
                    state <= S_FETCH;
                end
            endcase
        end
    end

    // operand latches
    always_ff @(posedge clk) begin
        if (state == S_READ_RD) begin
            rd_val <= reg_rdata;
        end
        if (state == S_READ_RA) begin
            ra_val <= has_imm8 ? {{(DATA_WIDTH-8){1'b0}}, imm8} : reg_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (reset) req |=> !req);

endmodule

/* verilog/vm16_decoder.sv */
// instruction decoder: register selects, immediates, ALU op and flags
`timescale 1ns/1ps

module vm16_decoder import vm16_pkg::*; (
    input  instr_t                   instr,
    output logic [REG_SEL_WIDTH-1:0] rd,
    output logic [REG_SEL_WIDTH-1:0] ra,
    output logic [7:0]               imm8,
    output logic [4:0]               simm5,
    output alu_op_e                  alu_op,
    output logic                     has_imm8,
    output logic                     has_we,
    output logic                     has_mem,
    output logic                     has_mem_we
);
    // rd sits in the same place in both forms
    assign rd    = instr.i.rd;
    assign imm8  = instr.i.imm8;
    assign ra    = instr.r.ra;
    assign simm5 = instr.r.simm5;

    always_comb begin
        alu_op     = ALU_NOP;
        has_imm8   = 1'b0;
        has_we     = 1'b0;
        has_mem    = 1'b0;
        has_mem_we = 1'b0;
        case (instr.r.opcode)
            OP_LW: begin
                alu_op  = ALU_LW;
                has_we  = 1'b1;
                has_mem = 1'b1;
            end
            OP_SW: begin
                alu_op     = ALU_SW;
                has_mem    = 1'b1;
                has_mem_we = 1'b1;
            end
            OP_MOV: begin
                alu_op = ALU_MOV;
                has_we = 1'b1;
            end
            OP_MOVI: begin
                alu_op   = ALU_MOVI;
                has_we   = 1'b1;
                has_imm8 = 1'b1;
            end
            OP_BIT: begin
                has_we = 1'b1;
                case (instr.r.simm5)
                    FN_OR:    alu_op = ALU_OR;
                    FN_XOR:   alu_op = ALU_XOR;
                    FN_AND:   alu_op = ALU_AND;
                    FN_NOT:   alu_op = ALU_NOT;
                    FN_LSHFT: alu_op = ALU_LSHFT;
                    FN_RSHFT: alu_op = ALU_RSHFT;
                    // unknown function runs as NOP
                    default:  has_we = 1'b0;
                endcase
            end
            OP_ARITH_U: begin
                has_we = 1'b1;
                case (instr.r.simm5)
                    FN_UADD: alu_op = ALU_UADD;
                    FN_USUB: alu_op = ALU_USUB;
                    default: has_we = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* verilog/vm16_gpio_apb.sv */
// APB slave with the GPIO output register
`timescale 1ns/1ps

module vm16_gpio_apb import vm16_pkg::*; #(
    parameter int GPIO_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pwrite,
    input  logic                  psel,
    input  logic                  penable,
    input  logic [DATA_WIDTH-1:0] pwdata,
    output logic [DATA_WIDTH-1:0] prdata,
    output logic                  pready,
    output logic [GPIO_WIDTH-1:0] gpio
);
    logic access;

    assign access = psel && penable;
    // always ready in the access phase
    assign pready = access;
    assign prdata = access ? {{(DATA_WIDTH-GPIO_WIDTH){1'b0}}, gpio} : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio <= '0;
        end else if (access && pwrite) begin
            gpio <= pwdata[GPIO_WIDTH-1:0];
        end
    end

endmodule

/* verilog/vm16_mmu.sv */
// memory unit: scratch RAM for low addresses, APB master for the rest
`timescale 1ns/1ps

module vm16_mmu import vm16_pkg::*; #(
    parameter int SCRATCH_DEPTH = 64
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    output logic                  busy,
    input  logic [DATA_WIDTH-1:0] mmu_addr,
    input  logic [DATA_WIDTH-1:0] mmu_wdata,
    input  logic                  mmu_we,
    output logic [DATA_WIDTH-1:0] mmu_rdata,
    output logic [DATA_WIDTH-1:0] paddr,
    output logic                  pwrite,
    output logic                  psel,
    output logic                  penable,
    output logic [DATA_WIDTH-1:0] pwdata,
    input  logic [DATA_WIDTH-1:0] prdata,
    input  logic                  pready
);
    localparam int SADDR_WIDTH = $clog2(SCRATCH_DEPTH);

    logic                  scratch_sel;
    logic                  apb_start;
    logic [DATA_WIDTH-1:0] scratch_rdata;
    logic [DATA_WIDTH-1:0] per_rdata;

    assign scratch_sel = mmu_addr < DATA_WIDTH'(SCRATCH_DEPTH);
    assign apb_start   = req && !scratch_sel && !psel;
    // psel marks an open transfer
    assign busy        = req || psel;
    assign mmu_rdata   = scratch_sel ? scratch_rdata : per_rdata;

    // idle -> setup (psel) -> access (penable) held until pready
    always_ff @(posedge clk) begin
        if (reset) begin
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end else if (apb_start) begin
            psel   <= 1'b1;
            pwrite <= mmu_we;
        end else if (penable && pready) begin
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end else if (psel) begin
            penable <= 1'b1;
        end
    end

    // request payload and captured read data
    always_ff @(posedge clk) begin
        if (apb_start) begin
            paddr  <= mmu_addr;
            pwdata <= mmu_wdata;
        end
        if (penable && pready) begin
            per_rdata <= prdata;
        end
    end

    vm16_bram #(
        .WIDTH (DATA_WIDTH),
        .DEPTH (SCRATCH_DEPTH)
    ) scratch_ram (
        .clk   (clk),
        .we    (mmu_we && scratch_sel),
        .waddr (mmu_addr[SADDR_WIDTH-1:0]),
        .wdata (mmu_wdata),
        .raddr (mmu_addr[SADDR_WIDTH-1:0]),
        .rdata (scratch_rdata)
    );

    assert property (@(posedge clk) disable iff (reset) penable |-> psel);
    // slave may stretch the access phase, the master has to wait it out
    assert property (@(posedge clk) disable iff (reset) psel && !pready |=> psel);

endmodule

/* verilog/vm16_pkg.sv */
// shared widths, opcode, function and ALU encodings
// plus the two-format instruction word
package vm16_pkg;

    localparam int DATA_WIDTH    = 16;
    localparam int REG_COUNT     = 8;
    localparam int REG_SEL_WIDTH = 3;

    // major opcode, top five bits of every instruction
    typedef enum logic [4:0] {
        OP_NOP     = 5'h00,
        OP_LW      = 5'h01,
        OP_SW      = 5'h02,
        OP_BIT     = 5'h03,
        OP_MOV     = 5'h04,
        OP_MOVI    = 5'h05,
        OP_ARITH_U = 5'h07
    } opcode_e;

    // low field of BIT and ARITH_U instructions
    typedef enum logic [4:0] {
        FN_OR    = 5'h00,
        FN_XOR   = 5'h01,
        FN_AND   = 5'h02,
        FN_NOT   = 5'h03,
        FN_LSHFT = 5'h04,
        FN_RSHFT = 5'h05,
        FN_USUB  = 5'h10,
        FN_UADD  = 5'h1f
    } func_e;

    typedef enum logic [4:0] {
        ALU_NOP   = 5'd0,
        ALU_LW    = 5'd1,
        ALU_SW    = 5'd2,
        ALU_MOV   = 5'd3,
        ALU_MOVI  = 5'd4,
        ALU_OR    = 5'd5,
        ALU_XOR   = 5'd6,
        ALU_AND   = 5'd7,
        ALU_NOT   = 5'd8,
        ALU_LSHFT = 5'd9,
        ALU_RSHFT = 5'd10,
        ALU_UADD  = 5'd11,
        ALU_USUB  = 5'd12
    } alu_op_e;

    // register form: opcode rd ra simm5/func
    typedef struct packed {
        opcode_e                  opcode;
        logic [REG_SEL_WIDTH-1:0] rd;
        logic [REG_SEL_WIDTH-1:0] ra;
        logic [4:0]               simm5;
    } instr_reg_t;

    // immediate form: opcode rd imm8
    typedef struct packed {
        opcode_e                  opcode;
        logic [REG_SEL_WIDTH-1:0] rd;
        logic [7:0]               imm8;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

endpackage

/* verilog/vm16_regfile.sv */
// eight-entry register file, async read and sync write
`timescale 1ns/1ps

module vm16_regfile import vm16_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [REG_SEL_WIDTH-1:0] rs,
    output logic [DATA_WIDTH-1:0]    rdata,
    input  logic                     we,
    input  logic [REG_SEL_WIDTH-1:0] ws,
    input  logic [DATA_WIDTH-1:0]    wdata
);
    logic [DATA_WIDTH-1:0] regs [REG_COUNT];

    // each register comes out of reset holding its own index
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= DATA_WIDTH'(i);
            end
        end else if (we) begin
            regs[ws] <= wdata;
        end
    end

    assign rdata = regs[rs];

    // writeback only happens once reset has been released
    assert property (@(posedge clk) we |-> !reset);

endmodule

/* verilog/vm16_soc.sv */
// top level: core, instruction memory, memory unit and GPIO slave
`timescale 1ns/1ps

module vm16_soc import vm16_pkg::*; #(
    parameter int INSTR_DEPTH   = 64,
    parameter int SCRATCH_DEPTH = 64,
    parameter int GPIO_WIDTH    = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           load_we,
    input  logic [$clog2(INSTR_DEPTH)-1:0] load_addr,
    input  logic [DATA_WIDTH-1:0]          load_data,
    output logic [GPIO_WIDTH-1:0]          gpio,
    output logic [DATA_WIDTH-1:0]          pc
);
    localparam int IADDR_WIDTH = $clog2(INSTR_DEPTH);

    logic [DATA_WIDTH-1:0]    instr_word;
    instr_t                   instr;
    logic [REG_SEL_WIDTH-1:0] rd;
    logic [REG_SEL_WIDTH-1:0] ra;
    logic [7:0]               imm8;
    logic [4:0]               simm5;
    alu_op_e                  alu_op;
    logic                     has_imm8;
    logic                     has_we;
    logic                     has_mem;
    logic                     has_mem_we;
    logic [REG_SEL_WIDTH-1:0] reg_rs;
    logic [DATA_WIDTH-1:0]    reg_rdata;
    logic                     reg_we;
    logic [DATA_WIDTH-1:0]    reg_wdata;
    logic [DATA_WIDTH-1:0]    alu_a;
    logic [DATA_WIDTH-1:0]    alu_b;
    logic [DATA_WIDTH-1:0]    alu_c;
    logic                     req;
    logic                     busy;
    logic [DATA_WIDTH-1:0]    mmu_addr;
    logic [DATA_WIDTH-1:0]    mmu_wdata;
    logic                     mmu_we;
    logic [DATA_WIDTH-1:0]    mmu_rdata;
    logic                     pwrite;
    logic                     psel;
    logic                     penable;
    logic [DATA_WIDTH-1:0]    pwdata;
    logic [DATA_WIDTH-1:0]    prdata;
    logic                     pready;

    // program is written through the load port while reset is held
    vm16_bram #(
        .WIDTH (DATA_WIDTH),
        .DEPTH (INSTR_DEPTH)
    ) imem (
        .clk   (clk),
        .we    (load_we),
        .waddr (load_addr),
        .wdata (load_data),
        .raddr (pc[IADDR_WIDTH-1:0]),
        .rdata (instr_word)
    );

    vm16_control #(
        .INSTR_DEPTH (INSTR_DEPTH)
    ) ctrl (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .instr_word (instr_word),
        .rd         (rd),
        .ra         (ra),
        .imm8       (imm8),
        .simm5      (simm5),
        .has_imm8   (has_imm8),
        .has_we     (has_we),
        .has_mem    (has_mem),
        .has_mem_we (has_mem_we),
        .reg_rs     (reg_rs),
        .reg_rdata  (reg_rdata),
        .reg_we     (reg_we),
        .reg_wdata  (reg_wdata),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_c      (alu_c),
        .req        (req),
        .busy       (busy),
        .mmu_addr   (mmu_addr),
        .mmu_wdata  (mmu_wdata),
        .mmu_we     (mmu_we),
        .mmu_rdata  (mmu_rdata),
        .instr      (instr)
    );

    vm16_decoder dec (
        .instr      (instr),
        .rd         (rd),
        .ra         (ra),
        .imm8       (imm8),
        .simm5      (simm5),
        .alu_op     (alu_op),
        .has_imm8   (has_imm8),
        .has_we     (has_we),
        .has_mem    (has_mem),
        .has_mem_we (has_mem_we)
    );

    // writeback always targets rd
    vm16_regfile regs (
        .clk   (clk),
        .reset (reset),
        .rs    (reg_rs),
        .rdata (reg_rdata),
        .we    (reg_we),
        .ws    (rd),
        .wdata (reg_wdata)
    );

    vm16_alu alu (
        .op (alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .c  (alu_c)
    );

    // single slave on the bus, nothing decodes paddr
    vm16_mmu #(
        .SCRATCH_DEPTH (SCRATCH_DEPTH)
    ) mmu (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .busy      (busy),
        .mmu_addr  (mmu_addr),
        .mmu_wdata (mmu_wdata),
        .mmu_we    (mmu_we),
        .mmu_rdata (mmu_rdata),
        .paddr     (),
        .pwrite    (pwrite),
        .psel      (psel),
        .penable   (penable),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready)
    );

    vm16_gpio_apb #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) gpio0 (
        .clk     (clk),
        .reset   (reset),
        .pwrite  (pwrite),
        .psel    (psel),
        .penable (penable),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .gpio    (gpio)
    );

endmodule
